// File: logic/xlat_pkg.sv
/* widths and types for the word to byte master translator; symbols per word must be a power
   of two and the byte address must hold the shifted word address */
`default_nettype none

package xlat_pkg;

   // --------------------
   // word side widths
   // --------------------
   localparam int AV_ADDRESS_W    = 32;
   localparam int AV_DATA_W       = 32;
   localparam int AV_BURSTCOUNT_W = 4;
   localparam int AV_BYTEENABLE_W = 4;

   // --------------------
   // byte side widths
   // --------------------
   localparam int UAV_ADDRESS_W    = 38;
   localparam int UAV_BURSTCOUNT_W = 10;

   // bytes per word and its log2
   localparam int SYMBOLS_PER_WORD = 4;
   localparam int WORD_SHIFT       = 2;

   // remaining beats, the symbol count without the byte bits
   localparam int UAV_BURSTLEN_W = UAV_BURSTCOUNT_W - WORD_SHIFT;

   // byte address on the universal port
   typedef logic [UAV_ADDRESS_W-1:0] uav_addr_t;

   // burst length in symbols
   typedef logic [UAV_BURSTCOUNT_W-1:0] uav_count_t;

   // burst length in beats
   typedef logic [UAV_BURSTLEN_W-1:0] burstlen_t;

endpackage

`default_nettype wire

// File: logic/cmd_if.sv
/* one converted request, held stable by the master while ready is low */
`timescale 1ns/100ps
`default_nettype none

interface cmd_if;
   import xlat_pkg::*;

   // request flags
   logic       valid;
   logic       write;
   logic       read;

   // request in byte units
   uav_addr_t  byte_addr;
   uav_count_t byte_count;
   burstlen_t  beats;

   // inverse of the slave wait-request
   logic       ready;

   modport source (
      output valid,
      output write,
      output read,
      output byte_addr,
      output byte_count,
      output beats,
      input  ready
   );

   // per-beat address and count tracking
   modport tracker (
      input write,
      input byte_addr,
      input byte_count,
      input beats,
      input ready
   );

   modport framer (
      input  valid,
      input  write,
      input  read,
      output ready
   );

endinterface

`default_nettype wire

// File: logic/command_decode.sv
/* word address and burst count are converted combinationally, no chipselect decoding */
`timescale 1ns/100ps
`default_nettype none

module command_decode (
   input  logic                                 av_read,
   input  logic                                 av_write,
   input  logic [xlat_pkg::AV_ADDRESS_W-1:0]    av_address,
   input  logic [xlat_pkg::AV_BURSTCOUNT_W-1:0] av_burstcount,
   cmd_if.source                                cmd
);
   import xlat_pkg::*;

   // padding above the shifted word address
   localparam int ADDR_PAD = UAV_ADDRESS_W - AV_ADDRESS_W - WORD_SHIFT;
   // padding above the word count
   localparam int BEAT_PAD = UAV_BURSTLEN_W - AV_BURSTCOUNT_W;

   // --------------------
   // request flags
   // --------------------
   assign cmd.read  = av_read;
   assign cmd.write = av_write;
   assign cmd.valid = av_read | av_write;

   // --------------------
   // address conversion
   // --------------------

   // word address times bytes per word, zero extended
   assign cmd.byte_addr = {{ADDR_PAD{1'b0}}, av_address, {WORD_SHIFT{1'b0}}};

   // --------------------
   // count conversion
   // --------------------

   // beats keep the word count, the symbol count scales it
   always_comb begin
      cmd.beats      = {{BEAT_PAD{1'b0}}, av_burstcount};
      cmd.byte_count = {cmd.beats, {WORD_SHIFT{1'b0}}};
   end

endmodule

`default_nettype wire

// File: logic/burst_tracker.sv
/* write bursts step the byte address per accepted beat; reads are one request for the whole
   burst, and the master must hold address and count stable while waiting */
`timescale 1ns/100ps
`default_nettype none

module burst_tracker (
   input  logic                 clk,
   input  logic                 reset,
   cmd_if.tracker               cmd,
   input  logic                 begin_transfer,
   input  logic                 begin_burst,
   output xlat_pkg::uav_addr_t  uav_address,
   output xlat_pkg::uav_count_t uav_burstcount,
   output logic                 last_beat
);
   import xlat_pkg::*;

   logic      wait_req;
   uav_addr_t addr_reg;
   uav_addr_t next_addr;
   burstlen_t burstlen_reg;
   logic      first_stalled;
   logic      stalled;
   logic      last_pre;
   logic      last_reg;

   assign wait_req = ~cmd.ready;

   // --------------------
   // output select
   // --------------------

   // burst start shows the fresh command, later beats the registers
   always_comb begin
      if (begin_burst) begin
         uav_address    = cmd.byte_addr;
         uav_burstcount = cmd.byte_count;
      end else begin
         uav_address    = addr_reg;
         uav_burstcount = {burstlen_reg, {WORD_SHIFT{1'b0}}};
      end
   end

   // compare both sources first, then pick
   assign last_pre  = (cmd.beats == burstlen_t'(1));
   assign last_reg  = (burstlen_reg == burstlen_t'(1));
   assign last_beat = begin_burst ? last_pre : last_reg;

   // --------------------
   // address stepping
   // --------------------
   assign next_addr = begin_burst ? cmd.byte_addr : addr_reg;

   // a waited beat reloads the current address so it is seen again
   always_ff @(posedge clk) begin
      if (wait_req) begin
         addr_reg <= next_addr;
      end else if (cmd.write) begin
         addr_reg <= next_addr + uav_addr_t'(SYMBOLS_PER_WORD);
      end
   end

   // --------------------
   // remaining beats
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burstlen_reg  <= '0;
         first_stalled <= 1'b0;
         stalled       <= 1'b0;
      end else begin
         if (begin_burst || first_stalled) begin
            // first beat, count from the command until it is taken
            first_stalled <= wait_req;
            if (wait_req) begin
               burstlen_reg <= cmd.beats;
            end else begin
               burstlen_reg <= cmd.beats - 1'b1;
            end
         end else if (begin_transfer || stalled) begin
            stalled <= wait_req;
            if (!wait_req) begin
               burstlen_reg <= burstlen_reg - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/transfer_framer.sv
/* transfer and burst starts are derived here, there are no external begin inputs;
   a beat is taken in the cycle the slave drops wait-request */
`timescale 1ns/100ps
`default_nettype none

module transfer_framer (
   input  logic   clk,
   input  logic   reset,
   cmd_if.framer  cmd,
   input  logic   uav_waitrequest,
   input  logic   last_beat,
   output logic   uav_read,
   output logic   uav_write,
   output logic   begin_transfer,
   output logic   begin_burst
);

   logic end_transfer;
   logic in_burst;

   // --------------------
   // request outputs
   // --------------------
   assign uav_read  = cmd.read;
   assign uav_write = cmd.write;

   // no wait-request allowance, ready follows the slave directly
   assign cmd.ready = ~uav_waitrequest;

   // --------------------
   // start markers
   // --------------------

   // first cycle of each beat only
   assign begin_transfer = cmd.valid & ~end_transfer;

   // every read starts a burst, writes only on their first beat
   always_comb begin
      if (cmd.read) begin
         begin_burst = begin_transfer;
      end else begin
         begin_burst = begin_transfer & ~in_burst;
      end
   end

   // --------------------
   // framing flags
   // --------------------

   // set while a started beat is still waiting
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_transfer <= 1'b0;
      end else begin
         end_transfer <= uav_waitrequest & (begin_transfer | end_transfer);
      end
   end

   // inside a write burst after its first beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_burst <= 1'b0;
      end else begin
         if ((last_beat && begin_transfer) || cmd.read) begin
            in_burst <= 1'b0;
         end else if (cmd.write && begin_transfer) begin
            in_burst <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/master_translator.sv
/* word-addressed bursting master in, byte-addressed universal master out; requests pass
   combinationally, reads need readdatavalid and wait-request allowance is zero */
`timescale 1ns/100ps
`default_nettype none

module master_translator (
   input  logic                                    clk,
   input  logic                                    reset,

   // word side master
   input  logic                                    av_read,
   input  logic                                    av_write,
   input  logic [xlat_pkg::AV_ADDRESS_W-1:0]       av_address,
   input  logic [xlat_pkg::AV_BURSTCOUNT_W-1:0]    av_burstcount,
   input  logic [xlat_pkg::AV_BYTEENABLE_W-1:0]    av_byteenable,
   input  logic [xlat_pkg::AV_DATA_W-1:0]          av_writedata,
   output logic [xlat_pkg::AV_DATA_W-1:0]          av_readdata,
   output logic                                    av_readdatavalid,
   output logic                                    av_waitrequest,

   // universal side
   output logic                                    uav_read,
   output logic                                    uav_write,
   output logic [xlat_pkg::UAV_ADDRESS_W-1:0]      uav_address,
   output logic [xlat_pkg::UAV_BURSTCOUNT_W-1:0]   uav_burstcount,
   output logic [xlat_pkg::AV_BYTEENABLE_W-1:0]    uav_byteenable,
   output logic [xlat_pkg::AV_DATA_W-1:0]          uav_writedata,
   input  logic [xlat_pkg::AV_DATA_W-1:0]          uav_readdata,
   input  logic                                    uav_readdatavalid,
   input  logic                                    uav_waitrequest
);

   logic begin_transfer;
   logic begin_burst;
   logic last_beat;

   cmd_if cmd ();

   // --------------------
   // pass-through paths
   // --------------------
   assign uav_writedata    = av_writedata;
   assign uav_byteenable   = av_byteenable;
   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;

   // stall goes straight back to the master
   assign av_waitrequest = uav_waitrequest;

   // --------------------
   // command path
   // --------------------
   command_decode i_decode (
      .av_read       (av_read),
      .av_write      (av_write),
      .av_address    (av_address),
      .av_burstcount (av_burstcount),
      .cmd           (cmd.source)
   );

   burst_tracker i_tracker (
      .clk            (clk),
      .reset          (reset),
      .cmd            (cmd.tracker),
      .begin_transfer (begin_transfer),
      .begin_burst    (begin_burst),
      .uav_address    (uav_address),
      .uav_burstcount (uav_burstcount),
      .last_beat      (last_beat)
   );

   transfer_framer i_framer (
      .clk             (clk),
      .reset           (reset),
      .cmd             (cmd.framer),
      .uav_waitrequest (uav_waitrequest),
      .last_beat       (last_beat),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst)
   );

endmodule

`default_nettype wire

// File: tb/tb_slave_model.sv
/* universal-port slave with 128 words indexed by byte address bits 8:2; read data is
   captured when the read is taken and returned in order, at least one cycle later */
`timescale 1ns/100ps
`default_nettype none

module tb_slave_model (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  uav_read,
   input  logic                                  uav_write,
   input  logic [xlat_pkg::UAV_ADDRESS_W-1:0]    uav_address,
   input  logic [xlat_pkg::UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input  logic [xlat_pkg::AV_BYTEENABLE_W-1:0]  uav_byteenable,
   input  logic [xlat_pkg::AV_DATA_W-1:0]        uav_writedata,
   output logic [xlat_pkg::AV_DATA_W-1:0]        uav_readdata,
   output logic                                  uav_readdatavalid,
   output logic                                  uav_waitrequest,
   input  logic [2:0]                            wait_cycles,
   input  logic [2:0]                            read_latency
);
   import xlat_pkg::*;

   logic [AV_DATA_W-1:0] mem [0:127];
   logic [AV_DATA_W-1:0] data_q [$];
   int                   due_q [$];
   int                   cycle = 0;
   int                   last_due = 0;
   logic [2:0]           wait_cnt;
   logic                 request;
   logic                 accept;
   logic [6:0]           index;

   assign request         = uav_read | uav_write;
   assign uav_waitrequest = request & (wait_cnt < wait_cycles);
   assign accept          = request & ~uav_waitrequest;
   assign index           = uav_address[8:WORD_SHIFT];

   // fill pattern spread over every bit of the word index
   initial begin : fill_memory
      int i;
      for (i = 0; i < 128; i++) begin
         mem[i] = (i * 32'h9e3779b1) ^ 32'h5ac30f96;
      end
   end

   // wait states counted per beat, cleared when the beat is taken
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt <= '0;
      end else if (accept) begin
         wait_cnt <= '0;
      end else if (request) begin
         wait_cnt <= wait_cnt + 3'd1;
      end
   end

   // --------------------
   // memory and read return
   // --------------------
   always @(posedge clk or posedge reset) begin : transfer
      int beat;
      int due;
      if (reset) begin
         data_q.delete();
         due_q.delete();
         uav_readdatavalid <= 1'b0;
         uav_readdata      <= '0;
      end else begin
         cycle = cycle + 1;
         if (due_q.size() != 0 && due_q[0] <= cycle) begin
            uav_readdatavalid <= 1'b1;
            uav_readdata      <= data_q.pop_front();
            void'(due_q.pop_front());
         end else begin
            uav_readdatavalid <= 1'b0;
         end
         if (accept && uav_write) begin
            for (beat = 0; beat < 4; beat++) begin
               if (uav_byteenable[beat]) begin
                  mem[index][8*beat +: 8] = uav_writedata[8*beat +: 8];
               end
            end
         end
         // one read covers the whole burst, words come back back to back or later
         if (accept && uav_read) begin
            due = cycle + 1 + int'(read_latency);
            for (beat = 0; beat < int'(uav_burstcount) / SYMBOLS_PER_WORD; beat++) begin
               if (due <= last_due) begin
                  due = last_due + 1;
               end
               data_q.push_back(mem[7'(int'(index) + beat)]);
               due_q.push_back(due);
               last_due = due;
               due      = due + 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
/* random bursts on word addresses below 64 against the 128-word slave model; reads are
   checked in order and one reset is pulsed in the middle of a write burst */
`timescale 1ns/100ps
`default_nettype none

module tb_top;
   import xlat_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int N_CMDS       = 200;
   localparam int MAX_BURST    = 8;
   // longest wait plus longest read latency plus an idle cycle
   localparam int LONGEST_WAIT = 16;
   localparam int WATCHDOG_NS  = (N_CMDS + 10) * MAX_BURST * LONGEST_WAIT * CLK_PERIOD;

   logic                        clk = 1'b0;
   logic                        reset;
   logic                        av_read;
   logic                        av_write;
   logic [AV_ADDRESS_W-1:0]     av_address;
   logic [AV_BURSTCOUNT_W-1:0]  av_burstcount;
   logic [AV_BYTEENABLE_W-1:0]  av_byteenable;
   logic [AV_DATA_W-1:0]        av_writedata;
   logic [AV_DATA_W-1:0]        av_readdata;
   logic                        av_readdatavalid;
   logic                        av_waitrequest;
   logic                        uav_read;
   logic                        uav_write;
   logic [UAV_ADDRESS_W-1:0]    uav_address;
   logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount;
   logic [AV_BYTEENABLE_W-1:0]  uav_byteenable;
   logic [AV_DATA_W-1:0]        uav_writedata;
   logic [AV_DATA_W-1:0]        uav_readdata;
   logic                        uav_readdatavalid;
   logic                        uav_waitrequest;
   logic [2:0]                  wait_cycles;
   logic [2:0]                  read_latency;

   logic [31:0] lfsr_state = 32'hb71f4bb6;
   logic [31:0] ref_mem [0:127];
   logic [31:0] exp_read_q [$];
   int          errors = 0;
   int          checks = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   master_translator i_dut (.*);
   tb_slave_model i_slave (.*);

   // --------------------
   // helpers
   // --------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h80200003;
      end
      return state >> 1;
   endfunction

   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] value;
      int          i;
      value = '0;
      for (i = 0; i < count; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      assert (expected == actual) else begin
         errors++;
         $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      end
   endtask

   task automatic write_mirror(input int word, input logic [31:0] data, input logic [3:0] be);
      int b;
      for (b = 0; b < 4; b++) begin
         if (be[b]) begin
            ref_mem[word][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   // one request; a read is a single beat, a write may stop short of len
   task automatic run_burst(input logic is_read, input int word, input int len,
                            input int beats_to_run);
      int          beat;
      int          i;
      logic        stalled;
      logic [31:0] data;
      logic [3:0]  be;
      string       name;
      beat    = 0;
      stalled = 1'b0;
      while (beat < beats_to_run) begin
         @(negedge clk);
         if (!stalled) begin
            data         = take_bits(32);
            be           = 4'(take_bits(4));
            wait_cycles  = 3'(take_bits(3));
            read_latency = 3'(take_bits(3));
         end
         av_read       = is_read;
         av_write      = !is_read;
         av_address    = AV_ADDRESS_W'(word);
         av_burstcount = AV_BURSTCOUNT_W'(len);
         av_writedata  = data;
         av_byteenable = be;
         #1;
         name = "write burst stepping";
         if (beat == 0) begin
            name = "address conversion";
         end
         // a waited beat is shown again with the same address and count
         if (stalled) begin
            name = "stall holding";
         end
         check_value(name, 64'((word + beat) * SYMBOLS_PER_WORD), 64'(uav_address));
         check_value(name, 64'((len - beat) * SYMBOLS_PER_WORD), 64'(uav_burstcount));
         check_value("request pass-through", 64'({is_read, !is_read}),
                     64'({uav_read, uav_write}));
         check_value("stall holding", 64'(uav_waitrequest), 64'(av_waitrequest));
         if (!is_read) begin
            check_value("data pass-through", 64'(data), 64'(uav_writedata));
            check_value("data pass-through", 64'(be), 64'(uav_byteenable));
         end
         stalled = av_waitrequest;
         @(posedge clk);
         if (!stalled) begin
            if (is_read) begin
               for (i = 0; i < len; i++) begin
                  exp_read_q.push_back(ref_mem[word + i]);
               end
            end else begin
               write_mirror(word + beat, data, be);
            end
            beat++;
         end
      end
   endtask

   task automatic drive_idle();
      @(negedge clk);
      av_read  = 1'b0;
      av_write = 1'b0;
   endtask

   // read data is stable between the edges
   always @(negedge clk) begin : read_monitor
      logic [31:0] expected;
      if (av_readdatavalid) begin
         assert (exp_read_q.size() != 0) else begin
            errors++;
            $display("read data arrived while no read was pending");
         end
         if (exp_read_q.size() != 0) begin
            expected = exp_read_q.pop_front();
            check_value("read return", 64'(expected), 64'(av_readdata));
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog: run did not finish within %0d ns, %0d errors so far",
               WATCHDOG_NS, errors);
      $display("=== FAIL ===");
      $finish;
   end

   // --------------------
   // stimulus
   // --------------------
   initial begin : main
      int   i;
      int   word;
      int   len;
      logic is_read;
      reset         = 1'b1;
      av_read       = 1'b0;
      av_write      = 1'b0;
      av_address    = '0;
      av_burstcount = '0;
      av_byteenable = '0;
      av_writedata  = '0;
      wait_cycles   = '0;
      read_latency  = '0;
      for (i = 0; i < 128; i++) begin
         ref_mem[i] = (i * 32'h9e3779b1) ^ 32'h5ac30f96;
      end
      repeat (10) @(negedge clk);
      reset = 1'b0;
      for (i = 0; i < N_CMDS; i++) begin
         is_read = take_bits(1) != 0;
         word    = int'(take_bits(6));
         len     = int'(take_bits(3)) + 1;
         run_burst(is_read, word, len, is_read ? 1 : len);
         if (take_bits(1) != 0) begin
            drive_idle();
         end
      end
      drive_idle();
      while (exp_read_q.size() != 0) @(negedge clk);
      // cut a write burst after two beats, the next request must start fresh
      run_burst(1'b0, 10, 6, 2);
      @(negedge clk);
      av_write = 1'b0;
      reset    = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      run_burst(1'b0, 40, 4, 4);
      run_burst(1'b1, 40, 4, 1);
      run_burst(1'b1, 10, 6, 1);
      drive_idle();
      while (exp_read_q.size() != 0) @(negedge clk);
      repeat (12) @(negedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
logic/xlat_pkg.sv
logic/cmd_if.sv
logic/command_decode.sv
logic/burst_tracker.sv
logic/transfer_framer.sv
logic/master_translator.sv
tb/tb_slave_model.sv
tb/tb_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_top
RTL_TOP  = master_translator
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed"; exit 1; fi

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
